/* verilog/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_OR  = 2'd3
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } res_src_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_WB   = 2'd1,
        FWD_MEM  = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic            valid;
        logic [31:0]     instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_plus4;
    } fd_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        res_src_e              res_src;
        logic                  mem_write;
        logic                  branch;
        logic                  jump;
        alu_op_e               alu_op;
        logic                  alu_src;   // Immediate as second operand
        logic [XLEN-1:0]       rd1;
        logic [XLEN-1:0]       rd2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pc_plus4;
    } de_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        res_src_e              res_src;
        logic                  mem_write;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       write_data;  // Store data
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc_plus4;
    } em_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        res_src_e              res_src;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       read_data;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc_plus4;
    } mw_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
    input  logic [31:0]                   imem_data_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    input  logic                          pc_src_i,
    input  logic [XLEN-1:0]               pc_target_i,
    output fd_t                           fd_o
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    logic [31:0]     imem [IMEM_DEPTH];
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4;
    logic [31:0]     instr;
    fd_t             fd_q;

    assign pc_plus4 = pc_q + 32'd4;
    assign instr    = imem[pc_q[IMEM_AW+1:2]];  // Word addressed, async read

    // Program load port, only open while the core is held in reset
    always_ff @(posedge clk_i) begin
        if (rst_i && imem_we_i) begin
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= '0;
        end else if (pc_src_i) begin
            pc_q <= pc_target_i;                // Taken branch or jump
        end else if (!stall_i) begin
            pc_q <= pc_plus4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fd_q.valid <= 1'b0;
        end else if (flush_i) begin
            fd_q.valid <= 1'b0;                 // Squash wrong-path fetch
        end else if (!stall_i) begin
            fd_q <= '{valid: 1'b1, instr: instr, pc: pc_q, pc_plus4: pc_plus4};
        end
    end

    assign fd_o = fd_q;

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  fd_t                   fd_i,
    input  wb_t                   wb_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output de_t                   de_o
);

    logic [XLEN-1:0]       regs [32];
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm_i, imm_s, imm_b, imm_j, imm;
    logic [XLEN-1:0]       rd1, rd2;
    logic                  supported, use_rs1, use_rs2;
    logic                  reg_write, mem_write, branch, jump, alu_src;
    res_src_e              res_src;
    alu_op_e               alu_op;
    de_t                   de_q;

    assign opcode = opcode_e'(fd_i.instr[6:0]);
    assign funct3 = fd_i.instr[14:12];

    assign imm_i = {{20{fd_i.instr[31]}}, fd_i.instr[31:20]};
    assign imm_s = {{20{fd_i.instr[31]}}, fd_i.instr[31:25], fd_i.instr[11:7]};
    assign imm_b = {{19{fd_i.instr[31]}}, fd_i.instr[31], fd_i.instr[7],
                    fd_i.instr[30:25], fd_i.instr[11:8], 1'b0};
    assign imm_j = {{11{fd_i.instr[31]}}, fd_i.instr[31], fd_i.instr[19:12],
                    fd_i.instr[20], fd_i.instr[30:21], 1'b0};

    always_comb begin
        supported = 1'b1;
        reg_write = 1'b0;
        res_src   = RES_ALU;
        mem_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        alu_op    = ALU_ADD;
        alu_src   = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        imm       = imm_i;
        case (opcode)
            OP: begin
                reg_write = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                case (funct3)
                    3'b000:  alu_op = fd_i.instr[30] ? ALU_SUB : ALU_ADD;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            OP_IMM: begin                          // ADDI only
                reg_write = 1'b1;
                alu_src   = 1'b1;
                use_rs1   = 1'b1;
                supported = (funct3 == 3'b000);
            end
            LOAD: begin                            // LW only
                reg_write = 1'b1;
                res_src   = RES_MEM;
                alu_src   = 1'b1;
                use_rs1   = 1'b1;
                supported = (funct3 == 3'b010);
            end
            STORE: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                imm       = imm_s;
                supported = (funct3 == 3'b010);
            end
            BRANCH: begin                          // BEQ only
                branch    = 1'b1;
                alu_op    = ALU_SUB;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                imm       = imm_b;
                supported = (funct3 == 3'b000);
            end
            JAL: begin
                reg_write = 1'b1;
                res_src   = RES_PC4;
                jump      = 1'b1;
                imm       = imm_j;
            end
            default: supported = 1'b0;
        endcase
    end

    // Unused source fields read as x0 so they never look like a hazard
    assign rs1   = use_rs1 ? fd_i.instr[19:15] : '0;
    assign rs2   = use_rs2 ? fd_i.instr[24:20] : '0;
    assign rs1_o = rs1;
    assign rs2_o = rs2;

    always_ff @(posedge clk_i) begin
        if (wb_i.we) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Same-cycle write passes straight through to the read
    assign rd1 = (rs1 == '0) ? '0 : (wb_i.we && wb_i.rd == rs1) ? wb_i.data : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : (wb_i.we && wb_i.rd == rs2) ? wb_i.data : regs[rs2];

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i || stall_i) begin
            de_q.valid <= 1'b0;                    // Bubble
        end else begin
            de_q <= '{valid: fd_i.valid && supported, reg_write: reg_write,
                      res_src: res_src, mem_write: mem_write, branch: branch,
                      jump: jump, alu_op: alu_op, alu_src: alu_src, rd1: rd1,
                      rd2: rd2, rs1: rs1, rs2: rs2, rd: fd_i.instr[11:7], imm: imm,
                      pc: fd_i.pc, pc_plus4: fd_i.pc_plus4};
        end
    end

    assign de_o = de_q;

endmodule

/* verilog/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
    input  de_t                   de_i,
    input  em_t                   em_i,
    input  wb_t                   wb_i,
    input  logic [REG_ADDR_W-1:0] rs1_d_i,
    input  logic [REG_ADDR_W-1:0] rs2_d_i,
    input  logic                  pc_src_i,
    output fwd_sel_e              fwd_a_o,
    output fwd_sel_e              fwd_b_o,
    output logic                  stall_f_o,
    output logic                  stall_d_o,
    output logic                  flush_d_o,
    output logic                  flush_e_o
);

    logic load_use;

    // Youngest producer wins, so memory stage is checked first
    function automatic fwd_sel_e fwd_select(logic [REG_ADDR_W-1:0] rs, em_t em, wb_t wb);
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (em.valid && em.reg_write && em.rd != '0 && em.rd == rs) begin
            sel = FWD_MEM;
        end else if (wb.we && wb.rd == rs) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_a_o = fwd_select(de_i.rs1, em_i, wb_i);
    assign fwd_b_o = fwd_select(de_i.rs2, em_i, wb_i);

    // Load result not ready until writeback
    assign load_use = de_i.valid && de_i.res_src == RES_MEM && de_i.rd != '0 &&
                      (de_i.rd == rs1_d_i || de_i.rd == rs2_d_i);

    assign stall_f_o = load_use;
    assign stall_d_o = load_use;
    assign flush_d_o = pc_src_i;
    assign flush_e_o = load_use || pc_src_i;

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  de_t             de_i,
    input  fwd_sel_e        fwd_a_i,
    input  fwd_sel_e        fwd_b_i,
    input  wb_t             wb_i,
    output logic            pc_src_o,
    output logic [XLEN-1:0] pc_target_o,
    output em_t             em_o
);

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_result;
    em_t             em_q;

    function automatic logic [XLEN-1:0] fwd_mux(fwd_sel_e sel, logic [XLEN-1:0] reg_val,
                                                logic [XLEN-1:0] mem_val,
                                                logic [XLEN-1:0] wb_val);
        logic [XLEN-1:0] val;
        case (sel)
            FWD_MEM: val = mem_val;
            FWD_WB:  val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    assign src_a   = fwd_mux(fwd_a_i, de_i.rd1, em_q.alu_result, wb_i.data);
    assign rs2_val = fwd_mux(fwd_b_i, de_i.rd2, em_q.alu_result, wb_i.data);
    assign src_b   = de_i.alu_src ? de_i.imm : rs2_val;

    always_comb begin
        case (de_i.alu_op)
            ALU_SUB: alu_result = src_a - src_b;
            ALU_AND: alu_result = src_a & src_b;
            ALU_OR:  alu_result = src_a | src_b;
            default: alu_result = src_a + src_b;
        endcase
    end

    // Resolved here, the two younger slots get flushed
    assign pc_src_o    = de_i.valid && (de_i.jump || (de_i.branch && src_a == rs2_val));
    assign pc_target_o = de_i.pc + de_i.imm;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            em_q.valid <= 1'b0;
        end else begin
            em_q <= '{valid: de_i.valid, reg_write: de_i.reg_write,
                      res_src: de_i.res_src, mem_write: de_i.mem_write,
                      alu_result: alu_result, write_data: rs2_val, rd: de_i.rd,
                      pc_plus4: de_i.pc_plus4};
        end
    end

    assign em_o = em_q;

endmodule

/* verilog/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage import rv_pkg::*; #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  em_t             em_i,
    output wb_t             wb_o,
    output logic            store_valid_o,
    output logic [XLEN-1:0] store_addr_o,
    output logic [XLEN-1:0] store_data_o
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0]    dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] word_idx;
    logic               store_en;
    logic               store_valid_q;
    logic [XLEN-1:0]    store_addr_q;
    logic [XLEN-1:0]    store_data_q;
    mw_t                mw_q;

    assign word_idx = em_i.alu_result[DMEM_AW+1:2];
    assign store_en = em_i.valid && em_i.mem_write;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (store_en) begin
            dmem[word_idx] <= em_i.write_data;
        end
    end

    // Store port mirrors each write one cycle later
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            store_valid_q <= 1'b0;
        end else begin
            store_valid_q <= store_en;
        end
        store_addr_q <= em_i.alu_result;
        store_data_q <= em_i.write_data;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mw_q.valid <= 1'b0;
        end else begin
            mw_q <= '{valid: em_i.valid, reg_write: em_i.reg_write,
                      res_src: em_i.res_src, alu_result: em_i.alu_result,
                      read_data: dmem[word_idx], rd: em_i.rd, pc_plus4: em_i.pc_plus4};
        end
    end

    always_comb begin
        wb_o.we = mw_q.valid && mw_q.reg_write && (mw_q.rd != '0);  // x0 never retires
        wb_o.rd = mw_q.rd;
        case (mw_q.res_src)
            RES_MEM: wb_o.data = mw_q.read_data;
            RES_PC4: wb_o.data = mw_q.pc_plus4;
            default: wb_o.data = mw_q.alu_result;
        endcase
    end

    assign store_valid_o = store_valid_q;
    assign store_addr_o  = store_addr_q;
    assign store_data_o  = store_data_q;

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import rv_pkg::*; #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
    input  logic [31:0]                   imem_data_i,
    output logic                          wb_valid_o,
    output logic [REG_ADDR_W-1:0]         wb_rd_o,
    output logic [XLEN-1:0]               wb_data_o,
    output logic                          store_valid_o,
    output logic [XLEN-1:0]               store_addr_o,
    output logic [XLEN-1:0]               store_data_o
);

    fd_t                   fd;
    de_t                   de;
    em_t                   em;
    wb_t                   wb;
    logic [REG_ADDR_W-1:0] rs1_d, rs2_d;
    logic                  pc_src;
    logic [XLEN-1:0]       pc_target;
    fwd_sel_e              fwd_a, fwd_b;
    logic                  stall_f, stall_d, flush_d, flush_e;

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .clk_i(clk_i), .rst_i(rst_i),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
        .stall_i(stall_f), .flush_i(flush_d),
        .pc_src_i(pc_src), .pc_target_i(pc_target),
        .fd_o(fd)
    );

    decode_stage u_decode (
        .clk_i(clk_i), .rst_i(rst_i),
        .fd_i(fd), .wb_i(wb),
        .stall_i(stall_d), .flush_i(flush_e),  // Either one leaves a bubble in de
        .rs1_o(rs1_d), .rs2_o(rs2_d),
        .de_o(de)
    );

    hazard_unit u_hazard (
        .de_i(de), .em_i(em), .wb_i(wb),
        .rs1_d_i(rs1_d), .rs2_d_i(rs2_d), .pc_src_i(pc_src),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b),
        .stall_f_o(stall_f), .stall_d_o(stall_d),
        .flush_d_o(flush_d), .flush_e_o(flush_e)
    );

    execute_stage u_execute (
        .clk_i(clk_i), .rst_i(rst_i),
        .de_i(de), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .wb_i(wb),
        .pc_src_o(pc_src), .pc_target_o(pc_target),
        .em_o(em)
    );

    memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (
        .clk_i(clk_i), .rst_i(rst_i),
        .em_i(em), .wb_o(wb),
        .store_valid_o(store_valid_o), .store_addr_o(store_addr_o),
        .store_data_o(store_data_o)
    );

    assign wb_valid_o = wb.we;
    assign wb_rd_o    = wb.rd;
    assign wb_data_o  = wb.data;

endmodule

/* test/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import rv_pkg::*; ();

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
    localparam int TIMEOUT    = 50;   // Cycles allowed between two expected events
    localparam int QUIET      = 12;   // Idle cycles that close a run
    localparam int RUN_LIMIT  = 400;  // Cycles allowed for one whole run

    typedef enum logic [3:0] {
        K_ADD, K_SUB, K_AND, K_OR, K_ADDI, K_LW, K_SW, K_BEQ, K_JAL
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
    } instr_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } store_t;

    logic                  clk_i;
    logic                  rst_i;
    logic                  imem_we_i;
    logic [IMEM_AW-1:0]    imem_addr_i;
    logic [31:0]           imem_data_i;
    logic                  wb_valid_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;
    logic                  store_valid_o;
    logic [XLEN-1:0]       store_addr_o;
    logic [XLEN-1:0]       store_data_o;

    logic [31:0]     prog_code [$];
    instr_t          prog_info [$];
    wb_t             exp_wb [$];
    store_t          exp_st [$];
    logic [XLEN-1:0] model_regs [32];
    logic [XLEN-1:0] model_mem [int];
    logic [31:0]     rng_state;
    int              errors;
    int              tests_run;
    int              tests_failed;

    cpu_top #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) dut (
        .clk_i(clk_i), .rst_i(rst_i),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .store_valid_o(store_valid_o), .store_addr_o(store_addr_o),
        .store_data_o(store_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_imm();
        logic [31:0] r;
        r = xorshift32();
        return {{20{r[11]}}, r[11:0]};   // Signed 12-bit range
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    function automatic void add_instr(kind_e kind, logic [4:0] rd, logic [4:0] rs1,
                                      logic [4:0] rs2, logic [31:0] imm);
        logic [31:0] code;
        case (kind)
            K_ADD:   code = enc_r(7'h00, rs2, rs1, 3'b000, rd);
            K_SUB:   code = enc_r(7'h20, rs2, rs1, 3'b000, rd);
            K_AND:   code = enc_r(7'h00, rs2, rs1, 3'b111, rd);
            K_OR:    code = enc_r(7'h00, rs2, rs1, 3'b110, rd);
            K_ADDI:  code = enc_i(imm, rs1, 3'b000, rd, OP_IMM);
            K_LW:    code = enc_i(imm, rs1, 3'b010, rd, LOAD);
            K_SW:    code = enc_s(imm, rs2, rs1);
            K_BEQ:   code = enc_b(imm, rs2, rs1);
            default: code = enc_j(imm, rd);
        endcase
        prog_code.push_back(code);
        prog_info.push_back('{kind: kind, rd: rd, rs1: rs1, rs2: rs2, imm: imm});
    endfunction

    // Instruction-level model, walks the program until the closing self loop
    task automatic run_model();
        logic [31:0] pc, next_pc, a, b, addr, val;
        logic        wr;
        instr_t      ins;
        int          steps;
        exp_wb.delete();
        exp_st.delete();
        model_mem.delete();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        pc    = '0;
        steps = 0;
        while (steps < 256) begin
            if (pc[31:2] >= prog_info.size()) begin
                $display("Model ran past the end of the program at pc %h", pc);
                errors++;
                break;
            end
            ins = prog_info[pc[31:2]];
            if (ins.kind == K_JAL && ins.imm == 0) begin
                break;
            end
            a       = model_regs[ins.rs1];
            b       = model_regs[ins.rs2];
            wr      = 1'b1;
            val     = '0;
            next_pc = pc + 4;
            case (ins.kind)
                K_ADD:  val = a + b;
                K_SUB:  val = a - b;
                K_AND:  val = a & b;
                K_OR:   val = a | b;
                K_ADDI: val = a + ins.imm;
                K_LW: begin
                    addr = a + ins.imm;
                    val  = model_mem.exists(addr[DMEM_AW+1:2]) ? model_mem[addr[DMEM_AW+1:2]] : '0;
                end
                K_SW: begin
                    wr   = 1'b0;
                    addr = a + ins.imm;
                    model_mem[addr[DMEM_AW+1:2]] = b;
                    exp_st.push_back('{addr: addr, data: b});
                end
                K_BEQ: begin
                    wr = 1'b0;
                    if (a == b) begin
                        next_pc = pc + ins.imm;
                    end
                end
                default: begin                          // JAL
                    val     = pc + 4;
                    next_pc = pc + ins.imm;
                end
            endcase
            if (wr && ins.rd != 0) begin                // x0 never retires
                model_regs[ins.rd] = val;
                exp_wb.push_back('{we: 1'b1, rd: ins.rd, data: val});
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        if (got.rd !== exp.rd) begin
            $display("FAIL wb_rd_o: got %h, expected %h", got.rd, exp.rd);
            errors++;
        end
        if (got.data !== exp.data) begin
            $display("FAIL wb_data_o (x%0d): got %h, expected %h", exp.rd, got.data, exp.data);
            errors++;
        end
    endtask

    task automatic check_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                               input store_t exp);
        if (addr !== exp.addr) begin
            $display("FAIL store_addr_o: got %h, expected %h", addr, exp.addr);
            errors++;
        end
        if (data !== exp.data) begin
            $display("FAIL store_data_o: got %h, expected %h", data, exp.data);
            errors++;
        end
    endtask

    // Holds reset while the program goes in, leaves reset high on return
    task automatic load_program();
        rst_i = 1'b1;
        for (int i = 0; i < prog_code.size(); i++) begin
            imem_we_i   = 1'b1;
            imem_addr_i = IMEM_AW'(i);
            imem_data_i = prog_code[i];
            @(negedge clk_i);
        end
        imem_we_i = 1'b0;
        repeat (2) @(negedge clk_i);
    endtask

    // Releases reset and matches every strobe against the model queues
    task automatic run_program(input int stop_after);
        int  idle;
        int  cycles;
        int  retired;
        bit  done;
        wb_t got;
        idle    = 0;
        cycles  = 0;
        retired = 0;
        done    = 1'b0;
        rst_i   = 1'b0;
        while (!done) begin
            @(negedge clk_i);
            idle++;
            cycles++;
            if (wb_valid_o === 1'b1) begin
                idle = 0;
                retired++;
                got = '{we: wb_valid_o, rd: wb_rd_o, data: wb_data_o};
                if (exp_wb.size() == 0) begin
                    $display("Retire of x%0d that the model does not expect", wb_rd_o);
                    errors++;
                end else begin
                    check_wb(got, exp_wb.pop_front());
                end
            end
            if (store_valid_o === 1'b1) begin
                idle = 0;
                if (exp_st.size() == 0) begin
                    $display("Store to %h that the model does not expect", store_addr_o);
                    errors++;
                end else begin
                    check_store(store_addr_o, store_data_o, exp_st.pop_front());
                end
            end
            if (stop_after > 0 && retired >= stop_after) begin
                done = 1'b1;
            end else if (cycles >= RUN_LIMIT) begin
                $display("Program still running after %0d cycles", cycles);
                errors++;
                done = 1'b1;
            end else if (exp_wb.size() == 0 && exp_st.size() == 0) begin
                done = (idle >= QUIET);                 // Quiet tail catches extra retires
            end else if (idle >= TIMEOUT) begin
                $display("Timeout after %0d idle cycles, %0d retires and %0d stores missing",
                         idle, exp_wb.size(), exp_st.size());
                errors++;
                done = 1'b1;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic start_program();
        prog_code.delete();
        prog_info.delete();
    endtask

    task automatic end_program();
        add_instr(K_JAL, 0, 0, 0, 0);                   // Self loop parks the core
        run_model();
        load_program();
    endtask

    task automatic test_alu_ops();
        int errs;
        errs = errors;
        start_program();
        add_instr(K_ADDI, 1, 0, 0, rand_imm());
        add_instr(K_ADDI, 2, 0, 0, rand_imm());
        add_instr(K_ADDI, 3, 1, 0, rand_imm());
        add_instr(K_ADD, 4, 1, 2, 0);
        add_instr(K_SUB, 5, 4, 3, 0);
        add_instr(K_AND, 6, 5, 2, 0);
        add_instr(K_OR, 7, 6, 1, 0);
        add_instr(K_ADDI, 0, 1, 0, rand_imm());         // Write to x0
        add_instr(K_ADD, 8, 7, 0, 0);
        end_program();
        run_program(0);
        report_test("alu_ops", errs);
    endtask

    task automatic test_forwarding();
        int errs;
        errs = errors;
        start_program();
        add_instr(K_ADDI, 10, 0, 0, rand_imm());
        add_instr(K_ADDI, 11, 10, 0, rand_imm());      // Distance 1
        add_instr(K_ADDI, 12, 0, 0, rand_imm());
        add_instr(K_ADD, 13, 10, 12, 0);               // Distances 3 and 1
        add_instr(K_ADDI, 14, 0, 0, rand_imm());
        add_instr(K_ADDI, 15, 0, 0, rand_imm());
        add_instr(K_SUB, 16, 14, 13, 0);               // Distances 2 and 3
        add_instr(K_OR, 17, 16, 16, 0);
        add_instr(K_AND, 18, 17, 15, 0);
        add_instr(K_ADDI, 19, 18, 0, rand_imm());
        add_instr(K_ADDI, 19, 19, 0, rand_imm());
        add_instr(K_SUB, 20, 19, 18, 0);               // Newest x19 must win
        end_program();
        run_program(0);
        report_test("forwarding", errs);
    endtask

    task automatic test_load_store();
        int errs;
        errs = errors;
        start_program();
        add_instr(K_ADDI, 1, 0, 0, 256);
        add_instr(K_ADDI, 2, 0, 0, rand_imm());
        add_instr(K_SW, 0, 1, 2, 8);
        add_instr(K_ADDI, 3, 0, 0, rand_imm());
        add_instr(K_SW, 0, 1, 3, 12);
        add_instr(K_LW, 4, 1, 0, 8);
        add_instr(K_ADD, 5, 4, 3, 0);                  // Load-use
        add_instr(K_LW, 6, 1, 0, 12);
        add_instr(K_SW, 0, 1, 6, 16);                  // Loaded value as store data
        add_instr(K_LW, 7, 1, 0, 16);
        add_instr(K_AND, 8, 7, 7, 0);
        end_program();
        run_program(0);
        report_test("load_store", errs);
    endtask

    task automatic test_branches();
        int errs;
        errs = errors;
        start_program();
        add_instr(K_ADDI, 1, 0, 0, 5);
        add_instr(K_ADDI, 2, 0, 0, 5);
        add_instr(K_ADDI, 3, 0, 0, 7);
        add_instr(K_BEQ, 0, 1, 2, 12);                 // Taken
        add_instr(K_ADDI, 4, 0, 0, 1);
        add_instr(K_ADDI, 5, 0, 0, 2);
        add_instr(K_ADDI, 6, 0, 0, 3);
        add_instr(K_BEQ, 0, 1, 3, 12);                 // Not taken
        add_instr(K_ADDI, 7, 0, 0, 4);
        add_instr(K_ADDI, 8, 0, 0, 5);
        add_instr(K_ADDI, 9, 0, 0, 6);
        end_program();
        run_program(0);
        report_test("branches", errs);
    endtask

    task automatic test_jump();
        int errs;
        errs = errors;
        start_program();
        add_instr(K_ADDI, 1, 0, 0, 3);
        add_instr(K_JAL, 5, 0, 0, 12);                 // pc 4 to pc 16
        add_instr(K_ADDI, 2, 0, 0, 9);
        add_instr(K_ADDI, 3, 0, 0, 9);
        add_instr(K_ADD, 4, 5, 1, 0);
        add_instr(K_JAL, 7, 0, 0, 8);                  // pc 20 to pc 28
        add_instr(K_ADDI, 8, 0, 0, 1);
        add_instr(K_ADDI, 9, 7, 0, 1);
        end_program();
        run_program(0);
        report_test("jump", errs);
    endtask

    task automatic test_reset();
        int errs;
        errs = errors;
        start_program();
        add_instr(K_ADDI, 1, 0, 0, rand_imm());
        add_instr(K_LW, 2, 0, 0, 64);                  // Reads cleared memory
        add_instr(K_SW, 0, 0, 1, 64);
        add_instr(K_LW, 3, 0, 0, 64);
        add_instr(K_ADD, 4, 3, 2, 0);
        add_instr(K_ADDI, 5, 4, 0, 1);
        add_instr(K_ADDI, 6, 5, 0, 1);
        end_program();
        run_program(3);
        rst_i = 1'b1;                                  // Mid-program reset
        for (int i = 0; i < 2; i++) begin
            @(negedge clk_i);
            if (wb_valid_o !== 1'b0 || store_valid_o !== 1'b0) begin
                $display("Retire or store strobe seen while reset is held");
                errors++;
            end
        end
        run_model();
        run_program(0);
        report_test("reset", errs);
    endtask

    initial begin
        rst_i        = 1'b1;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_data_i  = '0;
        rng_state    = 32'd16;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) @(negedge clk_i);
        test_alu_ops();
        test_forwarding();
        test_load_store();
        test_branches();
        test_jump();
        test_reset();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu_top.sv
test/cpu_tb.sv
